// File: Makefile
VERILATOR  ?= verilator
TOP        := pkt_sched_tb
FILELIST   := pkt_sched.f
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: core_msg_arbiter.sv
/* per-core message FIFOs and round-robin choice of the next message */
`timescale 1ns/1ps

module core_msg_arbiter import pkt_sched_pkg::*; (
  input  logic                       logic_clk,
  input  logic                       arst_n,
  input  logic [CORE_COUNT-1:0]      core_msg_valid,
  input  core_msg_t [CORE_COUNT-1:0] core_msg_data,
  output core_msg_t                  msg,
  output logic [CORE_IDX_W-1:0]      msg_core,
  output logic                       msg_valid,
  input  logic                       msg_ready
);

  core_msg_t mem [CORE_COUNT][CORE_FIFO_DEPTH];

  // one extra pointer bit tells full from empty
  logic [CORE_COUNT-1:0][CORE_FIFO_ADDR_SIZE:0] wr_ptr;
  logic [CORE_COUNT-1:0][CORE_FIFO_ADDR_SIZE:0] rd_ptr;
  logic [CORE_COUNT-1:0]                        fifo_empty;
  logic [CORE_COUNT-1:0]                        fifo_full;
  logic [CORE_COUNT-1:0]                        wr_en;
  logic [CORE_IDX_W-1:0]                        rr_ptr;
  logic                                         take;

  always_comb begin
    for (int c = 0; c < CORE_COUNT; c++) begin
      fifo_empty[c] = wr_ptr[c] == rd_ptr[c];
      fifo_full[c]  = wr_ptr[c] == {~rd_ptr[c][CORE_FIFO_ADDR_SIZE],
                                    rd_ptr[c][CORE_FIFO_ADDR_SIZE-1:0]};
      // strobe into a full FIFO is dropped
      wr_en[c]      = core_msg_valid[c] && !fifo_full[c];
    end
  end

  // first non-empty FIFO at or after rr_ptr
  always_comb begin
    int cand;
    cand      = 0;
    msg_valid = 1'b0;
    msg_core  = rr_ptr;
    for (int i = 0; i < CORE_COUNT; i++) begin
      cand = (int'(rr_ptr) + i) % CORE_COUNT;
      if (!msg_valid && !fifo_empty[cand]) begin
        msg_valid = 1'b1;
        msg_core  = CORE_IDX_W'(cand);
      end
    end
  end

  assign msg  = mem[msg_core][rd_ptr[msg_core][CORE_FIFO_ADDR_SIZE-1:0]];
  assign take = msg_valid && msg_ready;

  always_ff @(posedge logic_clk) begin
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (wr_en[c]) begin
        mem[c][wr_ptr[c][CORE_FIFO_ADDR_SIZE-1:0]] <= core_msg_data[c];
      end
    end
  end

  always_ff @(posedge logic_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      rr_ptr <= '0;
    end else begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        if (wr_en[c]) begin
          wr_ptr[c] <= wr_ptr[c] + 1'b1;
        end
      end
      if (take) begin
        rd_ptr[msg_core] <= rd_ptr[msg_core] + 1'b1;
        rr_ptr           <= CORE_IDX_W'((int'(msg_core) + 1) % CORE_COUNT);
      end else if (msg_valid) begin
        // pin the shown core until it is taken
        rr_ptr <= msg_core;
      end
    end
  end

endmodule

// File: pkt_sched.f
pkt_sched_pkg.sv
slot_tracker.sv
rx_dispatch.sv
core_msg_arbiter.sv
tx_dispatch.sv
pkt_sched_top.sv
pkt_sched_chk.sv
pkt_sched_tb.sv

// File: pkt_sched_chk.sv
/* bound checks on the descriptor channels, stall stability and known valids */
`timescale 1ns/1ps

module pkt_sched_chk import pkt_sched_pkg::*; (
  input logic  logic_clk,
  input logic  arst_n,
  input desc_t rx_desc,
  input logic  rx_desc_port,
  input logic  rx_desc_valid,
  input logic  rx_desc_ready,
  input desc_t tx_desc,
  input logic  tx_desc_port,
  input logic  tx_desc_valid,
  input logic  tx_desc_ready
);

  // failed assertion count
  int fail_cnt = 0;

  // a stalled descriptor keeps valid, contents and port
  rx_stall_hold: assert property (@(posedge logic_clk) disable iff (!arst_n)
    rx_desc_valid && !rx_desc_ready
      |=> rx_desc_valid && $stable(rx_desc) && $stable(rx_desc_port))
    else begin
      $error("rx descriptor changed while stalled");
      fail_cnt++;
    end

  tx_stall_hold: assert property (@(posedge logic_clk) disable iff (!arst_n)
    tx_desc_valid && !tx_desc_ready
      |=> tx_desc_valid && $stable(tx_desc) && $stable(tx_desc_port))
    else begin
      $error("tx descriptor changed while stalled");
      fail_cnt++;
    end

  valid_known: assert property (@(posedge logic_clk) disable iff (!arst_n)
    !$isunknown({rx_desc_valid, tx_desc_valid}))
    else begin
      $error("descriptor valid is unknown after reset");
      fail_cnt++;
    end

endmodule

bind pkt_sched_top pkt_sched_chk pkt_sched_chk_inst (
  .logic_clk     (logic_clk),
  .arst_n        (arst_n),
  .rx_desc       (rx_desc),
  .rx_desc_port  (rx_desc_port),
  .rx_desc_valid (rx_desc_valid),
  .rx_desc_ready (rx_desc_ready),
  .tx_desc       (tx_desc),
  .tx_desc_port  (tx_desc_port),
  .tx_desc_valid (tx_desc_valid),
  .tx_desc_ready (tx_desc_ready)
);

// File: pkt_sched_patterns.txt
# R rand set | F port n | M mask kind port slot len | E core slot port n
# T core slot port len n | W test (0 = checkpoint); hex fields, port 2 alternates
E 0 0 2 10
F 2 10
W 1
R 0 1
F 1 2
W 0
E 0 3 1 1
E 2 3 1 1
M 5 2 0 3 0
W 2
T 1 2 0 5ee 1
M 2 1 0 2 5ee
E 1 2 0 1
F 0 1
W 3
R 1 0
T 3 0 1 40 1
T 3 1 0 7c 1
M 8 1 1 0 40
M 8 1 0 1 7c
W 0
E 3 0 0 1
E 3 1 0 1
F 0 2
W 4
R 0 1
T 0 3 1 200 4
M f 1 1 3 200
W 5
E 0 3 0 4
F 0 4
M 1 3 0 0 0
F 1 1
W 6

// File: pkt_sched_pkg.sv
/* scheduler sizes, slot address constants, message kinds, descriptor and
   message types, slot address and tag helpers */
package pkt_sched_pkg;

  localparam int PORT_COUNT      = 2;
  localparam int CORE_COUNT      = 4;
  localparam int SLOT_COUNT      = 4;
  localparam int CORE_IDX_W      = $clog2(CORE_COUNT);
  localparam int SLOT_IDX_W      = $clog2(SLOT_COUNT);
  localparam int LEN_WIDTH       = 16;
  localparam int TAG_WIDTH       = 8;
  localparam int CORE_ADDR_WIDTH = 16;
  localparam int DESC_ADDR_W     = CORE_ADDR_WIDTH + CORE_IDX_W;

  // slot offsets inside a core, before the shift
  localparam int SLOT_LEAD_ZERO  = 8;
  localparam int FIRST_SLOT_ADDR = 'h40;
  localparam int SLOT_ADDR_STEP  = 'h08;
  localparam int RX_WRITE_OFFSET = 'h08;
  localparam logic [LEN_WIDTH-1:0] MAX_PKT_LEN =
    LEN_WIDTH'(SLOT_ADDR_STEP << SLOT_LEAD_ZERO);

  localparam int CORE_FIFO_ADDR_SIZE = 2;
  localparam int CORE_FIFO_DEPTH     = 2 ** CORE_FIFO_ADDR_SIZE;
  localparam int PEND_WIDTH          = 4;

  localparam int MSG_WIDTH  = 64;
  localparam int MSG_KIND_W = 2;
  localparam int MSG_FILL_W = MSG_WIDTH - MSG_KIND_W - 1 - SLOT_IDX_W - LEN_WIDTH;
  localparam logic [MSG_KIND_W-1:0] MSG_SEND = 2'd1;
  localparam logic [MSG_KIND_W-1:0] MSG_DROP = 2'd2;

  typedef struct packed {
    logic [CORE_IDX_W-1:0] core;
    logic [SLOT_IDX_W-1:0] slot;
  } slot_ref_t;

  typedef struct packed {
    logic [DESC_ADDR_W-1:0] addr;
    logic [LEN_WIDTH-1:0]   len;
    logic [TAG_WIDTH-1:0]   tag;
  } desc_t;

  // kind sits in the low bits of the core word
  typedef struct packed {
    logic [MSG_FILL_W-1:0] rsvd;
    logic [LEN_WIDTH-1:0]  len;
    logic [SLOT_IDX_W-1:0] slot;
    logic                  port;
    logic [MSG_KIND_W-1:0] kind;
  } core_msg_fields_t;

  typedef union packed {
    logic [MSG_WIDTH-1:0] raw;
    core_msg_fields_t     f;
  } core_msg_t;

  // core index on top, shifted slot offset below
  function automatic logic [DESC_ADDR_W-1:0] slot_addr(input slot_ref_t sr);
    logic [CORE_ADDR_WIDTH-1:0] offs;
    offs = CORE_ADDR_WIDTH'((FIRST_SLOT_ADDR + int'(sr.slot) * SLOT_ADDR_STEP)
                            << SLOT_LEAD_ZERO);
    return {sr.core, offs};
  endfunction

  function automatic logic [TAG_WIDTH-1:0] make_tag(input logic port, input slot_ref_t sr);
    return {port, {(TAG_WIDTH - 1 - $bits(slot_ref_t)){1'b0}}, sr};
  endfunction

endpackage

// File: pkt_sched_tb.sv
/* testbench for the packet scheduler with clock, reset, pattern reader,
   stimulus tasks, ready driver and descriptor monitors */
`timescale 1ns/1ps

module pkt_sched_tb import pkt_sched_pkg::*; ();

  typedef struct packed {
    desc_t d;
    logic  port;
  } exp_t;

  logic                       logic_clk;
  logic                       arst_n;
  logic [PORT_COUNT-1:0]      rx_pkt;
  logic [CORE_COUNT-1:0]      core_msg_valid;
  core_msg_t [CORE_COUNT-1:0] core_msg_data;
  desc_t                      rx_desc;
  logic                       rx_desc_port;
  logic                       rx_desc_valid;
  logic                       rx_desc_ready;
  desc_t                      tx_desc;
  logic                       tx_desc_port;
  logic                       tx_desc_valid;
  logic                       tx_desc_ready;

  // index 0 is the receive channel, 1 the transmit channel
  exp_t        exp_q [2][$];
  logic        rand_ready;
  logic        set_mode;
  logic [31:0] lcg_state;
  int          errors;
  int          checked;
  int          tests;

  pkt_sched_top pkt_sched_top_inst (.*);

  initial begin
    logic_clk = 1'b0;
    forever #2 logic_clk = ~logic_clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  initial begin
    logic [31:0] r;
    rx_desc_ready = 1'b1;
    tx_desc_ready = 1'b1;
    lcg_state     = 32'd21;
    forever begin
      @(negedge logic_clk);
      r = next_rand();
      rx_desc_ready = rand_ready ? r[16] : 1'b1;
      tx_desc_ready = rand_ready ? r[22] : 1'b1;
    end
  end

  // expected descriptor from the slot address and tag rules
  function automatic exp_t build_exp(input int ch, input int core, input int slot,
                                     input int port, input int len);
    exp_t e;
    int   offs;
    offs = (FIRST_SLOT_ADDR + slot * SLOT_ADDR_STEP) * (1 << SLOT_LEAD_ZERO);
    if (ch == 0) begin
      offs = offs + RX_WRITE_OFFSET;
    end
    e.d.addr = DESC_ADDR_W'(core * (1 << CORE_ADDR_WIDTH) + offs);
    e.d.len  = LEN_WIDTH'((ch == 0) ? (SLOT_ADDR_STEP << SLOT_LEAD_ZERO) : len);
    e.d.tag  = TAG_WIDTH'(port * 128 + core * SLOT_COUNT + slot);
    e.port   = port[0];
    return e;
  endfunction

  // slots advance core first, port 2 alternates from port 0
  task automatic push_expected(input int ch, input int core, input int slot, input int port,
                               input int len, input int count);
    int c;
    int s;
    c = core;
    s = slot;
    for (int k = 0; k < count; k++) begin
      exp_q[ch].push_back(build_exp(ch, c, s, (port == 2) ? k % 2 : port, len));
      c++;
      if (c == CORE_COUNT) begin
        c = 0;
        s++;
      end
    end
  endtask

  task automatic take_desc(input int ch, input exp_t got);
    int idx;
    idx = -1;
    checked++;
    if (set_mode) begin
      for (int i = 0; i < exp_q[ch].size(); i++) begin
        if (idx < 0 && exp_q[ch][i] == got) idx = i;
      end
    end else if (exp_q[ch].size() > 0 && exp_q[ch][0] == got) begin
      idx = 0;
    end
    assert (idx >= 0) else begin
      $display("MISMATCH at %0t: unexpected %s descriptor addr=%h len=%h tag=%h port=%0d",
               $time, (ch == 0) ? "rx" : "tx", got.d.addr, got.d.len, got.d.tag, got.port);
      errors++;
    end
    if (idx >= 0) begin
      exp_q[ch].delete(idx);
    end else if (!set_mode && exp_q[ch].size() > 0) begin
      void'(exp_q[ch].pop_front());
    end
  endtask

  always @(posedge logic_clk) begin
    if (arst_n && rx_desc_valid && rx_desc_ready) take_desc(0, {rx_desc, rx_desc_port});
    if (arst_n && tx_desc_valid && tx_desc_ready) take_desc(1, {tx_desc, tx_desc_port});
  end

  task automatic pulse_frames(input int port, input int count);
    int p;
    for (int k = 0; k < count; k++) begin
      p = (port == 2) ? k % 2 : port;
      @(negedge logic_clk);
      rx_pkt[p] = 1'b1;
      @(negedge logic_clk);
      rx_pkt = '0;
      repeat (2) @(negedge logic_clk);
    end
  endtask

  task automatic strobe_msgs(input int mask, input int kind, input int port, input int slot,
                             input int len);
    @(negedge logic_clk);
    for (int c = 0; c < CORE_COUNT; c++) begin
      core_msg_data[c] = '0;
      if (mask[c]) begin
        core_msg_valid[c]       = 1'b1;
        core_msg_data[c].f.kind = MSG_KIND_W'(kind);
        core_msg_data[c].f.port = port[0];
        core_msg_data[c].f.slot = SLOT_IDX_W'(slot);
        core_msg_data[c].f.len  = LEN_WIDTH'(len);
      end
    end
    @(negedge logic_clk);
    core_msg_valid = '0;
  endtask

  // drain expected queues, then a quiet window where any descriptor is stray
  task automatic wait_done(input int test_id);
    int cyc;
    cyc = 0;
    while ((exp_q[0].size() > 0 || exp_q[1].size() > 0) && cyc < 1000) begin
      @(negedge logic_clk);
      cyc++;
    end
    if (exp_q[0].size() > 0 || exp_q[1].size() > 0) begin
      $display("timeout at %0t: %0d rx and %0d tx descriptors never arrived",
               $time, exp_q[0].size(), exp_q[1].size());
      errors++;
      exp_q[0].delete();
      exp_q[1].delete();
    end
    repeat (20) @(negedge logic_clk);
    if (test_id != 0) begin
      tests++;
      $display("test %0d done, %0d errors so far", test_id, errors);
    end
  endtask

  initial begin
    int    fd;
    int    f0;
    int    f1;
    int    f2;
    int    f3;
    int    f4;
    string line;
    arst_n         = 1'b0;
    rx_pkt         = '0;
    core_msg_valid = '0;
    core_msg_data  = '0;
    rand_ready     = 1'b0;
    set_mode       = 1'b0;
    errors         = 0;
    checked        = 0;
    tests          = 0;
    repeat (8) @(negedge logic_clk);
    arst_n = 1'b1;
    @(negedge logic_clk);
    assert (!rx_desc_valid && !tx_desc_valid) else begin
      $display("MISMATCH at %0t: descriptor valid high right after reset", $time);
      errors++;
    end
    fd = $fopen("pkt_sched_patterns.txt", "r");
    if (fd == 0) begin
      $display("pattern file pkt_sched_patterns.txt could not be opened");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == "#") continue;
        f0 = 0;
        f1 = 0;
        f2 = 0;
        f3 = 0;
        f4 = 0;
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h", f0, f1, f2, f3, f4));
        case (line.getc(0))
          "R": begin
            rand_ready = f0[0];
            set_mode   = f1[0];
          end
          "F": pulse_frames(f0, f1);
          "M": strobe_msgs(f0, f1, f2, f3, f4);
          "E": push_expected(0, f0, f1, f2, 0, f3);
          "T": push_expected(1, f0, f1, f2, f3, f4);
          "W": wait_done(f0);
          default: begin
            $display("unknown pattern command in line: %s", line);
            errors++;
          end
        endcase
      end
      $fclose(fd);
    end
    // bound descriptor channel checks
    errors += pkt_sched_top_inst.pkt_sched_chk_inst.fail_cnt;
    $display("%0d tests done, %0d descriptors checked, %0d errors", tests, checked, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: pkt_sched_top.sv
/* scheduler top level, slot tracker with receive and transmit dispatch
   around the core message arbiter */
`timescale 1ns/1ps

module pkt_sched_top import pkt_sched_pkg::*; (
  input  logic                       logic_clk,
  input  logic                       arst_n,
  input  logic [PORT_COUNT-1:0]      rx_pkt,
  input  logic [CORE_COUNT-1:0]      core_msg_valid,
  input  core_msg_t [CORE_COUNT-1:0] core_msg_data,
  output desc_t                      rx_desc,
  output logic                       rx_desc_port,
  output logic                       rx_desc_valid,
  input  logic                       rx_desc_ready,
  output desc_t                      tx_desc,
  output logic                       tx_desc_port,
  output logic                       tx_desc_valid,
  input  logic                       tx_desc_ready
);

  logic                  alloc_req;
  logic                  alloc_ok;
  slot_ref_t             alloc_slot;
  logic                  rel_valid;
  slot_ref_t             rel_slot;
  core_msg_t             msg;
  logic [CORE_IDX_W-1:0] msg_core;
  logic                  msg_valid;
  logic                  msg_ready;

  slot_tracker slot_tracker_inst (
    .logic_clk  (logic_clk),
    .arst_n     (arst_n),
    .alloc_req  (alloc_req),
    .alloc_ok   (alloc_ok),
    .alloc_slot (alloc_slot),
    .rel_valid  (rel_valid),
    .rel_slot   (rel_slot)
  );

  rx_dispatch rx_dispatch_inst (
    .logic_clk     (logic_clk),
    .arst_n        (arst_n),
    .rx_pkt        (rx_pkt),
    .alloc_req     (alloc_req),
    .alloc_ok      (alloc_ok),
    .alloc_slot    (alloc_slot),
    .rx_desc       (rx_desc),
    .rx_desc_port  (rx_desc_port),
    .rx_desc_valid (rx_desc_valid),
    .rx_desc_ready (rx_desc_ready)
  );

  core_msg_arbiter core_msg_arbiter_inst (
    .logic_clk      (logic_clk),
    .arst_n         (arst_n),
    .core_msg_valid (core_msg_valid),
    .core_msg_data  (core_msg_data),
    .msg            (msg),
    .msg_core       (msg_core),
    .msg_valid      (msg_valid),
    .msg_ready      (msg_ready)
  );

  tx_dispatch tx_dispatch_inst (
    .logic_clk     (logic_clk),
    .arst_n        (arst_n),
    .msg           (msg),
    .msg_core      (msg_core),
    .msg_valid     (msg_valid),
    .msg_ready     (msg_ready),
    .tx_desc       (tx_desc),
    .tx_desc_port  (tx_desc_port),
    .tx_desc_valid (tx_desc_valid),
    .tx_desc_ready (tx_desc_ready),
    .rel_valid     (rel_valid),
    .rel_slot      (rel_slot)
  );

endmodule

// File: rx_dispatch.sv
/* waiting-frame counters per port, slot request and the receive
   descriptor register */
`timescale 1ns/1ps

module rx_dispatch import pkt_sched_pkg::*; (
  input  logic                  logic_clk,
  input  logic                  arst_n,
  input  logic [PORT_COUNT-1:0] rx_pkt,
  output logic                  alloc_req,
  input  logic                  alloc_ok,
  input  slot_ref_t             alloc_slot,
  output desc_t                 rx_desc,
  output logic                  rx_desc_port,
  output logic                  rx_desc_valid,
  input  logic                  rx_desc_ready
);

  logic [PORT_COUNT-1:0][PEND_WIDTH-1:0] pend_cnt;
  logic                                  pend_any;
  logic                                  sel_port;
  logic                                  grant;

  // lowest port with a waiting frame wins
  always_comb begin
    pend_any = 1'b0;
    sel_port = 1'b0;
    for (int p = PORT_COUNT - 1; p >= 0; p--) begin
      if (pend_cnt[p] != '0) begin
        pend_any = 1'b1;
        sel_port = 1'(p);
      end
    end
  end

  assign alloc_req = pend_any && !rx_desc_valid;
  assign grant     = alloc_req && alloc_ok;

  // saturating, a pulse at full count is lost
  always_ff @(posedge logic_clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_cnt <= '0;
    end else begin
      for (int p = 0; p < PORT_COUNT; p++) begin
        pend_cnt[p] <= pend_cnt[p]
                       + PEND_WIDTH'(rx_pkt[p] && pend_cnt[p] != '1)
                       - PEND_WIDTH'(grant && sel_port == 1'(p));
      end
    end
  end

  always_ff @(posedge logic_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_desc_valid <= 1'b0;
    end else if (grant) begin
      rx_desc_valid <= 1'b1;
    end else if (rx_desc_ready) begin
      rx_desc_valid <= 1'b0;
    end
  end

  // loaded only while no descriptor is held
  always_ff @(posedge logic_clk) begin
    if (grant) begin
      rx_desc.addr <= slot_addr(alloc_slot) + DESC_ADDR_W'(RX_WRITE_OFFSET);
      rx_desc.len  <= MAX_PKT_LEN;
      rx_desc.tag  <= make_tag(sel_port, alloc_slot);
      rx_desc_port <= sel_port;
    end
  end

endmodule

// File: slot_tracker.sv
/* free-slot map over all cores, round-robin core choice with lowest free
   slot, and slot release */
`timescale 1ns/1ps

module slot_tracker import pkt_sched_pkg::*; (
  input  logic      logic_clk,
  input  logic      arst_n,
  input  logic      alloc_req,
  output logic      alloc_ok,
  output slot_ref_t alloc_slot,
  input  logic      rel_valid,
  input  slot_ref_t rel_slot
);

  // bit set means slot is free
  logic [CORE_COUNT-1:0][SLOT_COUNT-1:0] free_map;
  logic [CORE_IDX_W-1:0]                 last_core;
  logic                                  take;

  // scan starts at the core after the last one served
  always_comb begin
    int cand;
    cand       = 0;
    alloc_ok   = 1'b0;
    alloc_slot = '0;
    for (int i = 1; i <= CORE_COUNT; i++) begin
      cand = (int'(last_core) + i) % CORE_COUNT;
      if (!alloc_ok && |free_map[cand]) begin
        alloc_ok        = 1'b1;
        alloc_slot.core = CORE_IDX_W'(cand);
        // downward walk leaves the lowest free slot
        for (int s = SLOT_COUNT - 1; s >= 0; s--) begin
          if (free_map[cand][s]) begin
            alloc_slot.slot = SLOT_IDX_W'(s);
          end
        end
      end
    end
  end

  assign take = alloc_req && alloc_ok;

  // an allocated slot is never the one being released
  always_ff @(posedge logic_clk or negedge arst_n) begin
    if (!arst_n) begin
      free_map  <= '1;
      last_core <= CORE_IDX_W'(CORE_COUNT - 1);
    end else begin
      if (take) begin
        free_map[alloc_slot.core][alloc_slot.slot] <= 1'b0;
        last_core                                  <= alloc_slot.core;
      end
      if (rel_valid) begin
        free_map[rel_slot.core][rel_slot.slot] <= 1'b1;
      end
    end
  end

endmodule

// File: tx_dispatch.sv
/* core message decode, transmit descriptor register and slot release */
`timescale 1ns/1ps

module tx_dispatch import pkt_sched_pkg::*; (
  input  logic                  logic_clk,
  input  logic                  arst_n,
  input  core_msg_t             msg,
  input  logic [CORE_IDX_W-1:0] msg_core,
  input  logic                  msg_valid,
  output logic                  msg_ready,
  output desc_t                 tx_desc,
  output logic                  tx_desc_port,
  output logic                  tx_desc_valid,
  input  logic                  tx_desc_ready,
  output logic                  rel_valid,
  output slot_ref_t             rel_slot
);

  slot_ref_t msg_slot;
  logic      accept;
  logic      is_send;
  logic      is_drop;
  logic      drop_rel;

  assign msg_slot = '{core: msg_core, slot: msg.f.slot};
  assign is_send  = msg.f.kind == MSG_SEND;
  assign is_drop  = msg.f.kind == MSG_DROP;

  // every kind waits while a transmit descriptor is held
  assign msg_ready = !tx_desc_valid;
  assign accept    = msg_valid && msg_ready;

  always_ff @(posedge logic_clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_desc_valid <= 1'b0;
      drop_rel      <= 1'b0;
    end else begin
      drop_rel <= accept && is_drop;
      if (accept && is_send) begin
        tx_desc_valid <= 1'b1;
      end else if (tx_desc_ready) begin
        tx_desc_valid <= 1'b0;
      end
    end
  end

  // slot of the last accepted message, kept while its descriptor waits
  always_ff @(posedge logic_clk) begin
    if (accept) begin
      rel_slot <= msg_slot;
    end
    if (accept && is_send) begin
      tx_desc.addr <= slot_addr(msg_slot);
      tx_desc.len  <= msg.f.len;
      tx_desc.tag  <= make_tag(msg.f.port, msg_slot);
      tx_desc_port <= msg.f.port;
    end
  end

  // send and drop releases never fall on the same cycle
  assign rel_valid = drop_rel || (tx_desc_valid && tx_desc_ready);

endmodule
